//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = rv_core_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = SIMULATION FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Test run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/rv_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_checker
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  dmem_req_t           dmem_req,
  input  logic                ebreak,
  input  logic                trap,
  input  logic                check_req,
  input  logic [8*16-1:0]     test_name,
  input  logic [`RV_XLEN-1:0] exp_addr,
  input  logic [`RV_XLEN-1:0] exp_data,
  input  logic [3:0]          exp_stores,
  input  logic                exp_ebreak,
  output int                  pass_count,
  output int                  fail_count
);

  logic [3:0]          stores;
  logic [`RV_XLEN-1:0] last_addr;
  logic [`RV_XLEN-1:0] last_data;
  logic                late_access;
  int                  mismatches;
  int                  passes = 0;
  int                  fails = 0;

  assign pass_count = passes;
  assign fail_count = fails;

  // ------------------------------
  // Comparison
  // ------------------------------

  task automatic compare_value(input string signal, input logic [`RV_XLEN-1:0] expected,
                               input logic [`RV_XLEN-1:0] actual);
    if (expected !== actual) begin
      $display("FAIL t=%0t %s %s expected %h got %h",
               $time, test_name, signal, expected, actual);
      mismatches++;
    end
  endtask

  task automatic evaluate_test();
    mismatches = 0;
    compare_value("store_count", 32'(exp_stores), 32'(stores));
    compare_value("store_addr", exp_addr, last_addr);
    compare_value("store_data", exp_data, last_data);
    compare_value("ebreak", 32'(exp_ebreak), 32'(ebreak));
    compare_value("trap", 32'(!exp_ebreak), 32'(trap));
    if (late_access) begin
      $display("FAIL t=%0t %s a data memory access reached the bus after the core halted",
               $time, test_name);
      mismatches++;
    end
    if (mismatches == 0) begin
      $display("PASS %s", test_name);
      passes++;
    end else begin
      $display("FAIL %s with %0d wrong checks", test_name, mismatches);
      fails++;
    end
  endtask

  // ------------------------------
  // Store and halt monitor
  // ------------------------------

  always @(posedge clk) begin
    if (!rst_n) begin
      stores      <= '0;
      last_addr   <= '0;
      last_data   <= '0;
      late_access <= 1'b0;
    end else begin
      if (dmem_req.we) begin
        stores    <= stores + 4'd1;
        last_addr <= dmem_req.addr;
        last_data <= dmem_req.wdata;
      end
      // Halted core must stay quiet on the bus
      if ((dmem_req.we || dmem_req.ren) && (ebreak || trap)) begin
        late_access <= 1'b1;
      end
      if (check_req) begin
        evaluate_test();
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_core_tb
  import rv_pkg::*;
();

  localparam int NTESTS      = 7;
  localparam int MAX_INSTR   = 8;
  localparam int DMEM_WORDS  = 16;
  localparam int CYCLE_LIMIT = NTESTS * MAX_INSTR * 2 + 50;

  // One row of the test table
  typedef struct packed {
    logic [8*16-1:0]              name;
    logic [0:7][`RV_XLEN-1:0]     prog;
    logic [`RV_XLEN-1:0]          addr;
    logic [`RV_XLEN-1:0]          data;
    logic [3:0]                   stores;
    logic                         is_ebreak;
  } test_t;

  logic                clk;
  logic                rst_n;
  logic [`RV_XLEN-1:0] imem_addr;
  logic [`RV_XLEN-1:0] imem_rdata;
  dmem_req_t           dmem_req;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic                ebreak;
  logic                trap;

  test_t               tests [NTESTS];
  test_t               cur;
  logic                check_req;
  logic [`RV_XLEN-1:0] dmem [DMEM_WORDS];
  int                  cycles = 0;
  int                  pass_count;
  int                  fail_count;

  rv_core dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_rdata(imem_rdata),
    .dmem_req  (dmem_req),
    .dmem_rdata(dmem_rdata),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  rv_checker chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .dmem_req  (dmem_req),
    .ebreak    (ebreak),
    .trap      (trap),
    .check_req (check_req),
    .test_name (cur.name),
    .exp_addr  (cur.addr),
    .exp_data  (cur.data),
    .exp_stores(cur.stores),
    .exp_ebreak(cur.is_ebreak),
    .pass_count(pass_count),
    .fail_count(fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // Memory models
  // ------------------------------

  // Words past the program read as zero, which is an illegal opcode
  assign imem_rdata = (imem_addr < MAX_INSTR * 4) ? cur.prog[imem_addr[4:2]] : '0;

  // Read data only comes back while the read enable is high
  assign dmem_rdata = dmem_req.ren ? dmem[dmem_req.addr[5:2]] : '0;

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= 32'hd0d0_0000 | 32'(i * 4);
      end
    end else if (dmem_req.we) begin
      dmem[dmem_req.addr[5:2]] <= dmem_req.wdata;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------

  task automatic run_test(input test_t row);
    @(negedge clk);
    cur   = row;
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    while (!(ebreak || trap)) begin
      @(negedge clk);
    end
    // A couple of idle cycles so a stray store would show up
    repeat (2) @(negedge clk);
    check_req = 1'b1;
    @(negedge clk);
    check_req = 1'b0;
  endtask

  initial begin
    rst_n     = 1'b0;
    check_req = 1'b0;
    cur       = '0;

    tests = '{
      '{"alu_add_sub_sll ",
        {32'h00500093, 32'hFFD00113, 32'h002081B3, 32'h40208233,
         32'h00321233, 32'h001202B3, 32'h00522023, 32'h00100073},
        32'h0000_0020, 32'h0000_0025, 4'd1, 1'b1},
      '{"alu_shift_slt   ",
        {32'hFF000093, 32'h4020D113, 32'h01C0D193, 32'h00312233,
         32'h00521213, 32'h003142B3, 32'h00522223, 32'h00100073},
        32'h0000_0024, 32'hFFFF_FFF3, 4'd1, 1'b1},
      '{"lui_ori_lw      ",
        {32'h123450B7, 32'h6780E093, 32'h00102423, 32'h00802103,
         32'h00202623, 32'h00100073, 32'h00000000, 32'h00000000},
        32'h0000_000C, 32'h1234_5678, 4'd2, 1'b1},
      '{"branches        ",
        {32'h00700093, 32'h00108463, 32'h00102023, 32'h00109463,
         32'h00102823, 32'h00100073, 32'h00000000, 32'h00000000},
        32'h0000_0010, 32'h0000_0007, 4'd1, 1'b1},
      '{"jal_jalr        ",
        {32'h00100113, 32'h00C000EF, 32'h00102A23, 32'h00100073,
         32'h00008067, 32'h00000000, 32'h00000000, 32'h00000000},
        32'h0000_0014, 32'h0000_0008, 4'd1, 1'b1},
      '{"ebreak_stops    ",
        {32'h05500093, 32'h00102C23, 32'h00100073, 32'h00002C23,
         32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000},
        32'h0000_0018, 32'h0000_0055, 4'd1, 1'b1},
      '{"illegal_sb_trap ",
        {32'h06600093, 32'h00102E23, 32'h00000E23, 32'h00002E23,
         32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000},
        32'h0000_001C, 32'h0000_0066, 4'd1, 1'b0}
    };

    for (int t = 0; t < NTESTS; t++) begin
      run_test(tests[t]);
    end

    $display("Tests run %0d, passed %0d, failed %0d", NTESTS, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/rv_pkg.sv
src/rv_pc_unit.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_core.sv
bench/rv_checker.sv
bench/rv_core_tb.sv

//--- src/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  output logic [`RV_XLEN-1:0] imem_addr,
  input  logic [`RV_XLEN-1:0] imem_rdata,
  output dmem_req_t           dmem_req,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic                ebreak,
  output logic                trap
);

  logic [`RV_XLEN-1:0]    pc_plus4;
  logic                   halted;
  logic                   redirect;
  logic [`RV_XLEN-1:0]    redirect_pc;
  logic                   illegal;
  logic                   is_ebreak;
  ctrl_t                  ctrl;
  logic [`RV_XLEN-1:0]    imm;
  logic [`RV_RADDR_W-1:0] rs1;
  logic [`RV_RADDR_W-1:0] rs2;
  logic [`RV_RADDR_W-1:0] rd;
  logic [`RV_XLEN-1:0]    rs1_data;
  logic [`RV_XLEN-1:0]    rs2_data;
  logic [`RV_XLEN-1:0]    wb_data;

  // Fetch address is the PC itself
  rv_pc_unit pc0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .illegal    (illegal),
    .is_ebreak  (is_ebreak),
    .pc         (imem_addr),
    .pc_plus4   (pc_plus4),
    .halted     (halted),
    .ebreak     (ebreak),
    .trap       (trap)
  );

  rv_decode dec0 (
    .instr    (imem_rdata),
    .halted   (halted),
    .ctrl     (ctrl),
    .imm      (imm),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .illegal  (illegal),
    .is_ebreak(is_ebreak)
  );

  rv_regfile rf0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .rd      (rd),
    .rd_we   (ctrl.reg_write),
    .rd_data (wb_data)
  );

  rv_execute ex0 (
    .ctrl       (ctrl),
    .imm        (imm),
    .pc         (imem_addr),
    .pc_plus4   (pc_plus4),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (dmem_req),
    .wb_data    (wb_data),
    .redirect   (redirect),
    .redirect_pc(redirect_pc)
  );

endmodule

`default_nettype wire

//--- src/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_decode
  import rv_pkg::*;
(
  input  instr_u                 instr,
  input  logic                   halted,
  output ctrl_t                  ctrl,
  output logic [`RV_XLEN-1:0]    imm,
  output logic [`RV_RADDR_W-1:0] rs1,
  output logic [`RV_RADDR_W-1:0] rs2,
  output logic [`RV_RADDR_W-1:0] rd,
  output logic                   illegal,
  output logic                   is_ebreak
);

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  // Shared funct3 map for OP and OP-IMM
  // The alt flag picks SUB or SRA
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Register fields sit at the same place in every format
  assign opcode = opcode_e'(instr.r.opcode);
  assign funct3 = instr.r.funct3;
  assign funct7 = instr.r.funct7;
  assign rs1    = instr.r.rs1;
  assign rs2    = instr.r.rs2;
  assign rd     = instr.r.rd;

  // ------------------------------
  // Immediates per format
  // ------------------------------

  assign imm_i = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{(`RV_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{(`RV_XLEN-13){instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                  instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
  assign imm_u = {instr.u.imm_31_12, 12'b0};
  assign imm_j = {{(`RV_XLEN-21){instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                  instr.j.imm_11, instr.j.imm_10_1, 1'b0};

  // ------------------------------
  // Control decode
  // ------------------------------

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    ctrl.wb_src = WB_ALU;
    ctrl.funct3 = funct3;
    imm         = '0;
    illegal     = 1'b0;
    is_ebreak   = 1'b0;

    case (opcode)
      OP_LUI: begin
        imm            = imm_u;
        ctrl.b_imm     = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.reg_write = 1'b1;
      end
      OP_AUIPC: begin
        imm            = imm_u;
        ctrl.a_pc      = 1'b1;
        ctrl.b_imm     = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      OP_JAL: begin
        imm            = imm_j;
        ctrl.a_pc      = 1'b1;
        ctrl.b_imm     = 1'b1;
        ctrl.is_jal    = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_src    = WB_PC4;
      end
      OP_JALR: begin
        imm            = imm_i;
        ctrl.b_imm     = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_src    = WB_PC4;
        illegal        = (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        imm            = imm_b;
        ctrl.is_branch = 1'b1;
        // funct3 010 and 011 are not branches
        illegal        = (funct3[2:1] == 2'b01);
      end
      OP_LOAD: begin
        imm            = imm_i;
        ctrl.b_imm     = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_src    = WB_LOAD;
        illegal        = (funct3 != 3'b010);
      end
      OP_STORE: begin
        imm            = imm_s;
        ctrl.b_imm     = 1'b1;
        ctrl.mem_write = 1'b1;
        illegal        = (funct3 != 3'b010);
      end
      OP_IMM: begin
        imm            = imm_i;
        ctrl.b_imm     = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
        // Shift immediates keep funct7 in the upper imm bits
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      OP_REG: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_from_funct3(funct3, funct7[5]);
        illegal        = !((funct7 == 7'b0000000) ||
                           ((funct7 == 7'b0100000) &&
                            ((funct3 == 3'b000) || (funct3 == 3'b101))));
      end
      OP_SYSTEM: begin
        // Only EBREAK is kept
        // ECALL and CSR accesses trap
        if ((instr.i.imm == 12'h001) && (instr.i.rs1 == '0) &&
            (instr.i.funct3 == 3'b000) && (instr.i.rd == '0)) begin
          is_ebreak = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    // No side effects from a halting instruction or a frozen core
    if (halted || illegal || is_ebreak) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// ------------------------------
// Core widths
// ------------------------------

// Data and address width
`define RV_XLEN 32

// Architectural register count and its address width
`define RV_NREGS 32
`define RV_RADDR_W 5

// ------------------------------
// Boot
// ------------------------------

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- src/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_execute
  import rv_pkg::*;
(
  input  ctrl_t               ctrl,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] pc_plus4,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output dmem_req_t           dmem_req,
  output logic [`RV_XLEN-1:0] wb_data,
  output logic                redirect,
  output logic [`RV_XLEN-1:0] redirect_pc
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [SHAMT_W-1:0]  shamt;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] br_target;
  logic                eq;
  logic                lt;
  logic                ltu;
  logic                taken;

  // ------------------------------
  // ALU
  // ------------------------------

  assign op_a  = ctrl.a_pc ? pc : rs1_data;
  assign op_b  = ctrl.b_imm ? imm : rs2_data;
  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SLT:    alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // ------------------------------
  // Branch and jump
  // ------------------------------

  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.funct3)
      3'b000:  taken = eq;
      3'b001:  taken = !eq;
      3'b100:  taken = lt;
      3'b101:  taken = !lt;
      3'b110:  taken = ltu;
      3'b111:  taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  // Branches keep the ALU free, jumps reuse its sum
  assign br_target   = pc + imm;
  assign redirect    = (ctrl.is_branch && taken) || ctrl.is_jal || ctrl.is_jalr;
  assign redirect_pc = ctrl.is_branch ? br_target : alu_result;

  // ------------------------------
  // Memory and write-back
  // ------------------------------

  assign dmem_req.ren   = ctrl.mem_read;
  assign dmem_req.we    = ctrl.mem_write;
  assign dmem_req.addr  = alu_result;
  assign dmem_req.wdata = rs2_data;

  always_comb begin
    case (ctrl.wb_src)
      WB_LOAD: wb_data = dmem_rdata;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

//--- src/rv_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_pc_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                redirect,
  input  logic [`RV_XLEN-1:0] redirect_pc,
  input  logic                illegal,
  input  logic                is_ebreak,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] pc_plus4,
  output logic                halted,
  output logic                ebreak,
  output logic                trap
);

  logic [`RV_XLEN-1:0] pc_next;
  logic                stop;

  assign pc_plus4 = pc + `RV_XLEN'd4;

  // Targets are forced onto a word boundary
  assign pc_next = redirect ? {redirect_pc[`RV_XLEN-1:2], 2'b00} : pc_plus4;

  // PC freezes on the halting instruction itself
  assign stop = halted || illegal || is_ebreak;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= `RV_RESET_PC;
      halted <= 1'b0;
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      if (!stop) begin
        pc <= pc_next;
      end
      // Sticky until reset
      if (!halted) begin
        halted <= illegal || is_ebreak;
        ebreak <= is_ebreak;
        trap   <= illegal;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

  // Major opcodes handled by the core, anything else traps
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_src_e;

  // ------------------------------
  // Instruction formats
  // ------------------------------

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One fetched word, seen through each format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  // ------------------------------
  // Decode to execute, and memory
  // ------------------------------

  typedef struct packed {
    alu_op_e    alu_op;
    logic       a_pc;
    logic       b_imm;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic [2:0] funct3;
    wb_src_e    wb_src;
  } ctrl_t;

  typedef struct packed {
    logic                ren;
    logic                we;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
  } dmem_req_t;

endpackage

`default_nettype wire

//--- src/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`RV_RADDR_W-1:0] rs1,
  input  logic [`RV_RADDR_W-1:0] rs2,
  output logic [`RV_XLEN-1:0]    rs1_data,
  output logic [`RV_XLEN-1:0]    rs2_data,
  input  logic [`RV_RADDR_W-1:0] rd,
  input  logic                   rd_we,
  input  logic [`RV_XLEN-1:0]    rd_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // x0 is never written, so a plain read yields zero
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0);

endmodule

`default_nettype wire
